//--- rtl/mips_isa_pkg.sv
package mips_isa_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'h00,
        OPC_J       = 6'h02,
        OPC_JAL     = 6'h03,
        OPC_BEQ     = 6'h04,
        OPC_BNE     = 6'h05,
        OPC_ADDIU   = 6'h09,
        OPC_SLTI    = 6'h0a,
        OPC_ANDI    = 6'h0c,
        OPC_ORI     = 6'h0d,
        OPC_LUI     = 6'h0f
    } opcode_t;

    // function codes under OPC_SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fields_t;

    // bits [25:0] double as the jump index of j and jal
    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_word_u;

    localparam reg_addr_t LINK_REG = 5'd31;
    localparam int        NUM_REGS = 32;

endpackage

//--- rtl/id_pkg.sv
package id_pkg;

    typedef enum logic [2:0] {
        ALU_NONE  = 3'd0,
        ALU_ARITH = 3'd1,
        ALU_LOGIC = 3'd2,
        ALU_SHIFT = 3'd3
    } alutype_t;

    typedef enum logic [7:0] {
        ALUOP_NOP  = 8'h00,
        ALUOP_ADDU = 8'h01,
        ALUOP_SUBU = 8'h02,
        ALUOP_AND  = 8'h03,
        ALUOP_OR   = 8'h04,
        ALUOP_XOR  = 8'h05,
        ALUOP_SLT  = 8'h06,
        ALUOP_SLL  = 8'h07,
        ALUOP_SRL  = 8'h08,
        ALUOP_LUI  = 8'h09,
        // execute stage writes the link address for this one
        ALUOP_JAL  = 8'h0a
    } aluop_t;

    typedef enum logic [2:0] {
        JMP_NONE = 3'd0,
        JMP_JUMP = 3'd1,
        JMP_REG  = 3'd2,
        JMP_BEQ  = 3'd3,
        JMP_BNE  = 3'd4
    } jump_kind_t;

    typedef struct packed {
        logic                    we;
        mips_isa_pkg::reg_addr_t addr;
        mips_isa_pkg::word_t     data;
    } reg_write_t;

    typedef struct packed {
        alutype_t   alutype;
        aluop_t     aluop;
        logic       wreg;
        logic       rreg1;
        logic       rreg2;
        logic       shift;
        logic       immsel;
        logic       sext;
        logic       upper;
        logic       rtsel;
        logic       link;
        jump_kind_t jump_kind;
    } ctrl_t;

    typedef struct packed {
        mips_isa_pkg::word_t     src1;
        mips_isa_pkg::word_t     src2;
        alutype_t                alutype;
        aluop_t                  aluop;
        logic                    wreg;
        mips_isa_pkg::reg_addr_t wa;
    } slot_out_t;

    typedef enum logic {
        ISSUE_SINGLE = 1'b0,
        ISSUE_DUAL   = 1'b1
    } issue_mode_t;

endpackage

//--- rtl/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  mips_isa_pkg::inst_word_u inst_i,
    output id_pkg::ctrl_t            ctrl_o,
    output mips_isa_pkg::reg_addr_t  wa_o
);
    import mips_isa_pkg::*;
    import id_pkg::*;

    // three-register ALU op, reads rs and rt, writes rd
    function automatic ctrl_t alu_rr(input alutype_t t, input aluop_t op);
        ctrl_t c;
        c         = '0;
        c.alutype = t;
        c.aluop   = op;
        c.wreg    = 1'b1;
        c.rreg1   = 1'b1;
        c.rreg2   = 1'b1;
        return c;
    endfunction

    // immediate ALU op, writes rt
    function automatic ctrl_t alu_ri(input alutype_t t, input aluop_t op, input logic sx);
        ctrl_t c;
        c         = '0;
        c.alutype = t;
        c.aluop   = op;
        c.wreg    = 1'b1;
        c.rreg1   = 1'b1;
        c.immsel  = 1'b1;
        c.rtsel   = 1'b1;
        c.sext    = sx;
        return c;
    endfunction

    always_comb begin
        ctrl_o = '0;
        case (inst_i.r.opcode)
            OPC_SPECIAL: begin
                case (inst_i.r.funct)
                    FN_ADDU: ctrl_o = alu_rr(ALU_ARITH, ALUOP_ADDU);
                    FN_SUBU: ctrl_o = alu_rr(ALU_ARITH, ALUOP_SUBU);
                    FN_SLT:  ctrl_o = alu_rr(ALU_ARITH, ALUOP_SLT);
                    FN_AND:  ctrl_o = alu_rr(ALU_LOGIC, ALUOP_AND);
                    FN_OR:   ctrl_o = alu_rr(ALU_LOGIC, ALUOP_OR);
                    FN_XOR:  ctrl_o = alu_rr(ALU_LOGIC, ALUOP_XOR);
                    FN_SLL, FN_SRL: begin
                        // shamt goes in as src1, rt is the value shifted
                        ctrl_o = alu_rr(ALU_SHIFT,
                                        (inst_i.r.funct == FN_SLL) ? ALUOP_SLL : ALUOP_SRL);
                        ctrl_o.rreg1 = 1'b0;
                        ctrl_o.shift = 1'b1;
                    end
                    FN_JR: begin
                        ctrl_o.rreg1     = 1'b1;
                        ctrl_o.jump_kind = JMP_REG;
                    end
                    default: ctrl_o = '0;
                endcase
            end
            OPC_ADDIU: ctrl_o = alu_ri(ALU_ARITH, ALUOP_ADDU, 1'b1);
            OPC_SLTI:  ctrl_o = alu_ri(ALU_ARITH, ALUOP_SLT, 1'b1);
            OPC_ANDI:  ctrl_o = alu_ri(ALU_LOGIC, ALUOP_AND, 1'b0);
            OPC_ORI:   ctrl_o = alu_ri(ALU_LOGIC, ALUOP_OR, 1'b0);
            OPC_LUI: begin
                ctrl_o       = alu_ri(ALU_LOGIC, ALUOP_LUI, 1'b0);
                ctrl_o.rreg1 = 1'b0;
                ctrl_o.upper = 1'b1;
            end
            OPC_BEQ, OPC_BNE: begin
                ctrl_o.rreg1     = 1'b1;
                ctrl_o.rreg2     = 1'b1;
                ctrl_o.jump_kind = (inst_i.r.opcode == OPC_BEQ) ? JMP_BEQ : JMP_BNE;
            end
            OPC_J: ctrl_o.jump_kind = JMP_JUMP;
            OPC_JAL: begin
                ctrl_o.alutype   = ALU_ARITH;
                ctrl_o.aluop     = ALUOP_JAL;
                ctrl_o.wreg      = 1'b1;
                ctrl_o.link      = 1'b1;
                ctrl_o.jump_kind = JMP_JUMP;
            end
            default: ctrl_o = '0;
        endcase
    end

    always_comb begin
        if (ctrl_o.link) begin
            wa_o = LINK_REG;
        end else if (ctrl_o.rtsel) begin
            wa_o = inst_i.i.rt;
        end else begin
            wa_o = inst_i.r.rd;
        end
    end

endmodule

//--- rtl/operand_select.sv
`timescale 1ns/1ns

module operand_select (
    input  mips_isa_pkg::inst_word_u inst_i,
    input  id_pkg::ctrl_t            ctrl_i,
    input  mips_isa_pkg::word_t      rdata1_i,
    input  mips_isa_pkg::word_t      rdata2_i,
    input  id_pkg::reg_write_t       exe_fwd_i [2],
    input  id_pkg::reg_write_t       mem_fwd_i [2],
    output mips_isa_pkg::word_t      src1_o,
    output mips_isa_pkg::word_t      src2_o
);
    import mips_isa_pkg::*;
    import id_pkg::*;

    // ordered oldest to newest
    reg_write_t fwd_src [4];
    word_t      imm_ext;

    // a disabled read port stays at the zero it got from the register file
    function automatic word_t resolve(input reg_addr_t ra, input logic en, input word_t rf_data);
        word_t val;
        val = rf_data;
        for (int k = 0; k < 4; k++) begin
            if (en && fwd_src[k].we && fwd_src[k].addr == ra && ra != '0) begin
                val = fwd_src[k].data;
            end
        end
        return val;
    endfunction

    always_comb begin
        fwd_src[0] = mem_fwd_i[0];
        fwd_src[1] = mem_fwd_i[1];
        fwd_src[2] = exe_fwd_i[0];
        fwd_src[3] = exe_fwd_i[1];
    end

    always_comb begin
        if (ctrl_i.upper) begin
            imm_ext = {inst_i.i.imm16, 16'h0000};
        end else if (ctrl_i.sext) begin
            imm_ext = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
        end else begin
            imm_ext = {16'h0000, inst_i.i.imm16};
        end
    end

    always_comb begin
        if (ctrl_i.shift) begin
            src1_o = {27'd0, inst_i.r.shamt};
        end else begin
            src1_o = resolve(inst_i.r.rs, ctrl_i.rreg1, rdata1_i);
        end

        if (ctrl_i.immsel) begin
            src2_o = imm_ext;
        end else begin
            src2_o = resolve(inst_i.r.rt, ctrl_i.rreg2, rdata2_i);
        end
    end

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                    clk,
    input  logic                    reset_i,
    input  id_pkg::reg_write_t      wb_i [2],
    input  mips_isa_pkg::reg_addr_t raddr_i [4],
    input  logic [3:0]              ren_i,
    output mips_isa_pkg::word_t     rdata_o [4]
);
    import mips_isa_pkg::*;

    word_t regs [NUM_REGS];

    // port 2 is written last, so it takes a shared address
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int n = 0; n < NUM_REGS; n++) begin
                regs[n] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (wb_i[p].we && wb_i[p].addr != '0) begin
                    regs[wb_i[p].addr] <= wb_i[p].data;
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            if (!ren_i[r] || raddr_i[r] == '0) begin
                rdata_o[r] = '0;
            end else if (wb_i[1].we && wb_i[1].addr == raddr_i[r]) begin
                rdata_o[r] = wb_i[1].data;
            end else if (wb_i[0].we && wb_i[0].addr == raddr_i[r]) begin
                rdata_o[r] = wb_i[0].data;
            end else begin
                rdata_o[r] = regs[raddr_i[r]];
            end
        end
    end

endmodule

//--- rtl/issue_ctrl.sv
`timescale 1ns/1ns

module issue_ctrl (
    input  id_pkg::ctrl_t            ctrl1_i,
    input  id_pkg::ctrl_t            ctrl2_i,
    input  mips_isa_pkg::inst_word_u inst1_i,
    input  mips_isa_pkg::inst_word_u inst2_i,
    input  mips_isa_pkg::reg_addr_t  wa1_i,
    input  mips_isa_pkg::reg_addr_t  wa2_i,
    output id_pkg::issue_mode_t      issue_mode_o
);
    import mips_isa_pkg::*;
    import id_pkg::*;

    logic any_jump;
    logic raw_dep;
    logic waw_dep;

    // control transfer straight from the opcode, jr lives under SPECIAL
    function automatic logic is_jump(input inst_word_u w);
        logic j;
        case (w.r.opcode)
            OPC_J, OPC_JAL, OPC_BEQ, OPC_BNE: j = 1'b1;
            OPC_SPECIAL: j = (w.r.funct == FN_JR);
            default: j = 1'b0;
        endcase
        return j;
    endfunction

    always_comb begin
        any_jump = is_jump(inst1_i) | is_jump(inst2_i);
        raw_dep  = ctrl1_i.wreg && wa1_i != '0 &&
                   ((ctrl2_i.rreg1 && inst2_i.r.rs == wa1_i) ||
                    (ctrl2_i.rreg2 && inst2_i.r.rt == wa1_i));
        waw_dep  = ctrl1_i.wreg && ctrl2_i.wreg && wa1_i != '0 && wa1_i == wa2_i;
        issue_mode_o = (any_jump || raw_dep || waw_dep) ? ISSUE_SINGLE : ISSUE_DUAL;
    end

endmodule

//--- rtl/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  mips_isa_pkg::word_t      pc_i,
    input  mips_isa_pkg::inst_word_u inst_i,
    input  id_pkg::ctrl_t            ctrl_i,
    input  mips_isa_pkg::word_t      src1_i,
    input  mips_isa_pkg::word_t      src2_i,
    output logic                     take_o,
    output mips_isa_pkg::word_t      target_o,
    output mips_isa_pkg::word_t      link_o
);
    import mips_isa_pkg::*;
    import id_pkg::*;

    word_t pc_plus4;
    word_t br_offset;
    logic  equal;

    assign pc_plus4  = pc_i + 32'd4;
    assign br_offset = {{14{inst_i.i.imm16[15]}}, inst_i.i.imm16, 2'b00};
    assign equal     = (src1_i == src2_i);
    assign link_o    = pc_i + 32'd8;

    always_comb begin
        case (ctrl_i.jump_kind)
            JMP_JUMP: begin
                target_o = {pc_plus4[31:28], inst_i.i[25:0], 2'b00};
                take_o   = 1'b1;
            end
            JMP_REG: begin
                target_o = src1_i;
                take_o   = 1'b1;
            end
            JMP_BEQ, JMP_BNE: begin
                target_o = pc_plus4 + br_offset;
                take_o   = (ctrl_i.jump_kind == JMP_BEQ) ? equal : !equal;
            end
            default: begin
                target_o = '0;
                take_o   = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic                     clk,
    input  logic                     reset_i,
    input  mips_isa_pkg::word_t      pc_i,
    input  mips_isa_pkg::inst_word_u inst1_i,
    input  mips_isa_pkg::inst_word_u inst2_i,
    input  id_pkg::reg_write_t       wb_i [2],
    input  id_pkg::reg_write_t       exe_fwd_i [2],
    input  id_pkg::reg_write_t       mem_fwd_i [2],
    output id_pkg::slot_out_t        slot1_o,
    output id_pkg::slot_out_t        slot2_o,
    output id_pkg::issue_mode_t      issue_mode_o,
    output logic                     jmp_take_o,
    output mips_isa_pkg::word_t      jmp_target_o,
    output mips_isa_pkg::word_t      link_addr_o
);
    import mips_isa_pkg::*;
    import id_pkg::*;

    ctrl_t     ctrl1;
    ctrl_t     ctrl2;
    reg_addr_t wa1;
    reg_addr_t wa2;
    reg_addr_t raddr [4];
    logic [3:0] ren;
    word_t     rdata [4];
    word_t     s1_src1;
    word_t     s1_src2;
    word_t     s2_src1;
    word_t     s2_src2;
    logic      take;

    inst_decoder u_dec1 (.inst_i(inst1_i), .ctrl_o(ctrl1), .wa_o(wa1));
    inst_decoder u_dec2 (.inst_i(inst2_i), .ctrl_o(ctrl2), .wa_o(wa2));

    // ports 0/1 serve slot 1, ports 2/3 serve slot 2
    always_comb begin
        raddr[0] = inst1_i.r.rs;
        raddr[1] = inst1_i.r.rt;
        raddr[2] = inst2_i.r.rs;
        raddr[3] = inst2_i.r.rt;
        ren      = {ctrl2.rreg2, ctrl2.rreg1, ctrl1.rreg2, ctrl1.rreg1};
    end

    regfile u_regfile (
        .clk     (clk),
        .reset_i (reset_i),
        .wb_i    (wb_i),
        .raddr_i (raddr),
        .ren_i   (ren),
        .rdata_o (rdata)
    );

    operand_select u_opsel1 (
        .inst_i    (inst1_i),
        .ctrl_i    (ctrl1),
        .rdata1_i  (rdata[0]),
        .rdata2_i  (rdata[1]),
        .exe_fwd_i (exe_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .src1_o    (s1_src1),
        .src2_o    (s1_src2)
    );

    operand_select u_opsel2 (
        .inst_i    (inst2_i),
        .ctrl_i    (ctrl2),
        .rdata1_i  (rdata[2]),
        .rdata2_i  (rdata[3]),
        .exe_fwd_i (exe_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .src1_o    (s2_src1),
        .src2_o    (s2_src2)
    );

    issue_ctrl u_issue (
        .ctrl1_i      (ctrl1),
        .ctrl2_i      (ctrl2),
        .inst1_i      (inst1_i),
        .inst2_i      (inst2_i),
        .wa1_i        (wa1),
        .wa2_i        (wa2),
        .issue_mode_o (issue_mode_o)
    );

    branch_unit u_branch (
        .pc_i     (pc_i),
        .inst_i   (inst1_i),
        .ctrl_i   (ctrl1),
        .src1_i   (s1_src1),
        .src2_i   (s1_src2),
        .take_o   (take),
        .target_o (jmp_target_o),
        .link_o   (link_addr_o)
    );

    assign jmp_take_o = take & ~reset_i;

    always_comb begin
        slot1_o.src1    = s1_src1;
        slot1_o.src2    = s1_src2;
        slot1_o.alutype = ctrl1.alutype;
        slot1_o.aluop   = ctrl1.aluop;
        slot1_o.wreg    = ctrl1.wreg & ~reset_i;
        slot1_o.wa      = wa1;

        // slot 2 is squashed when only slot 1 issues
        slot2_o = '0;
        if (issue_mode_o == ISSUE_DUAL) begin
            slot2_o.src1    = s2_src1;
            slot2_o.src2    = s2_src2;
            slot2_o.alutype = ctrl2.alutype;
            slot2_o.aluop   = ctrl2.aluop;
            slot2_o.wreg    = ctrl2.wreg & ~reset_i;
            slot2_o.wa      = wa2;
        end
    end

endmodule

//--- dv/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// decoded view of one instruction
typedef struct packed {
    alutype_t   at;
    aluop_t     op;
    logic       wreg;
    logic       rd_rs;
    logic       rd_rt;
    logic       use_shamt;
    logic       use_imm;
    word_t      imm;
    reg_addr_t  wa;
    jump_kind_t jk;
} dec_t;

typedef struct packed {
    slot_out_t   s1;
    slot_out_t   s2;
    issue_mode_t im;
    logic        take;
    word_t       target;
    word_t       link;
    jump_kind_t  jk1;
} expect_t;

word_t ref_regs [32];

task automatic update_model(input logic rst, input reg_write_t w [2]);
    if (rst) begin
        for (int n = 0; n < 32; n++) begin
            ref_regs[n] = '0;
        end
    end else begin
        for (int p = 0; p < 2; p++) begin
            if (w[p].we && w[p].addr != 5'd0) begin
                ref_regs[w[p].addr] = w[p].data;
            end
        end
    end
endtask

function automatic dec_t decode_ref(input inst_word_u w);
    dec_t d;
    logic [15:0] imm16;
    d = '0;
    imm16 = w.i.imm16;
    case (w.r.opcode)
        OPC_SPECIAL: begin
            d.rd_rs = 1'b1;
            d.rd_rt = 1'b1;
            d.wreg  = 1'b1;
            case (w.r.funct)
                FN_ADDU: begin d.at = ALU_ARITH; d.op = ALUOP_ADDU; end
                FN_SUBU: begin d.at = ALU_ARITH; d.op = ALUOP_SUBU; end
                FN_SLT:  begin d.at = ALU_ARITH; d.op = ALUOP_SLT; end
                FN_AND:  begin d.at = ALU_LOGIC; d.op = ALUOP_AND; end
                FN_OR:   begin d.at = ALU_LOGIC; d.op = ALUOP_OR; end
                FN_XOR:  begin d.at = ALU_LOGIC; d.op = ALUOP_XOR; end
                FN_SLL, FN_SRL: begin
                    d.at        = ALU_SHIFT;
                    d.op        = (w.r.funct == FN_SLL) ? ALUOP_SLL : ALUOP_SRL;
                    d.rd_rs     = 1'b0;
                    d.use_shamt = 1'b1;
                end
                FN_JR: begin
                    d.rd_rt = 1'b0;
                    d.wreg  = 1'b0;
                    d.jk    = JMP_REG;
                end
                default: d = '0;
            endcase
        end
        OPC_ADDIU, OPC_SLTI, OPC_ANDI, OPC_ORI, OPC_LUI: begin
            d.wreg    = 1'b1;
            d.rd_rs   = (w.r.opcode != OPC_LUI);
            d.use_imm = 1'b1;
            d.at      = (w.r.opcode == OPC_ADDIU || w.r.opcode == OPC_SLTI) ?
                        ALU_ARITH : ALU_LOGIC;
            case (w.r.opcode)
                OPC_ADDIU: d.op = ALUOP_ADDU;
                OPC_SLTI:  d.op = ALUOP_SLT;
                OPC_ANDI:  d.op = ALUOP_AND;
                OPC_ORI:   d.op = ALUOP_OR;
                default:   d.op = ALUOP_LUI;
            endcase
            if (w.r.opcode == OPC_LUI) begin
                d.imm = {imm16, 16'h0000};
            end else if (w.r.opcode == OPC_ADDIU || w.r.opcode == OPC_SLTI) begin
                d.imm = {{16{imm16[15]}}, imm16};
            end else begin
                d.imm = {16'h0000, imm16};
            end
        end
        OPC_BEQ, OPC_BNE: begin
            d.rd_rs = 1'b1;
            d.rd_rt = 1'b1;
            d.jk    = (w.r.opcode == OPC_BEQ) ? JMP_BEQ : JMP_BNE;
        end
        OPC_J: d.jk = JMP_JUMP;
        OPC_JAL: begin
            d.at   = ALU_ARITH;
            d.op   = ALUOP_JAL;
            d.wreg = 1'b1;
            d.jk   = JMP_JUMP;
        end
        default: d = '0;
    endcase
    if (w.r.opcode == OPC_JAL) begin
        d.wa = 5'd31;
    end else if (d.use_imm) begin
        d.wa = w.i.rt;
    end else begin
        d.wa = w.r.rd;
    end
    return d;
endfunction

// register file read with write bypass, then forwarding newest first
function automatic word_t operand_ref(input reg_addr_t a, input logic en,
                                      input reg_write_t wb [2],
                                      input reg_write_t exe [2],
                                      input reg_write_t mem [2]);
    word_t v;
    if (!en || a == 5'd0) begin
        return '0;
    end
    if (wb[1].we && wb[1].addr == a) begin
        v = wb[1].data;
    end else if (wb[0].we && wb[0].addr == a) begin
        v = wb[0].data;
    end else begin
        v = ref_regs[a];
    end
    if (exe[1].we && exe[1].addr == a) return exe[1].data;
    if (exe[0].we && exe[0].addr == a) return exe[0].data;
    if (mem[1].we && mem[1].addr == a) return mem[1].data;
    if (mem[0].we && mem[0].addr == a) return mem[0].data;
    return v;
endfunction

function automatic slot_out_t slot_ref(input inst_word_u w, input dec_t d, input logic rst,
                                       input reg_write_t wb [2],
                                       input reg_write_t exe [2],
                                       input reg_write_t mem [2]);
    slot_out_t s;
    s.src1    = d.use_shamt ? {27'd0, w.r.shamt} : operand_ref(w.r.rs, d.rd_rs, wb, exe, mem);
    s.src2    = d.use_imm ? d.imm : operand_ref(w.r.rt, d.rd_rt, wb, exe, mem);
    s.alutype = d.at;
    s.aluop   = d.op;
    s.wreg    = d.wreg & ~rst;
    s.wa      = d.wa;
    return s;
endfunction

function automatic expect_t expect_ref(input inst_word_u i1, input inst_word_u i2,
                                       input word_t pc, input logic rst,
                                       input reg_write_t wb [2],
                                       input reg_write_t exe [2],
                                       input reg_write_t mem [2]);
    expect_t e;
    dec_t d1;
    dec_t d2;
    logic raw;
    logic waw;
    word_t pc4;
    logic [31:0] w1;
    d1 = decode_ref(i1);
    d2 = decode_ref(i2);
    w1 = i1;
    e.s1 = slot_ref(i1, d1, rst, wb, exe, mem);
    e.s2 = slot_ref(i2, d2, rst, wb, exe, mem);
    raw = d1.wreg && d1.wa != 5'd0 &&
          ((d2.rd_rs && i2.r.rs == d1.wa) || (d2.rd_rt && i2.r.rt == d1.wa));
    waw = d1.wreg && d2.wreg && d1.wa != 5'd0 && d1.wa == d2.wa;
    e.im = (d1.jk != JMP_NONE || d2.jk != JMP_NONE || raw || waw) ? ISSUE_SINGLE : ISSUE_DUAL;
    if (e.im == ISSUE_SINGLE) begin
        e.s2 = '0;
    end
    pc4 = pc + 32'd4;
    e.jk1 = d1.jk;
    e.link = pc + 32'd8;
    case (d1.jk)
        JMP_JUMP: begin e.target = {pc4[31:28], w1[25:0], 2'b00}; e.take = 1'b1; end
        JMP_REG:  begin e.target = e.s1.src1; e.take = 1'b1; end
        JMP_BEQ, JMP_BNE: begin
            e.target = pc4 + {{14{w1[15]}}, w1[15:0], 2'b00};
            e.take   = (d1.jk == JMP_BEQ) ? (e.s1.src1 == e.s1.src2)
                                          : (e.s1.src1 != e.s1.src2);
        end
        default: begin e.target = '0; e.take = 1'b0; end
    endcase
    e.take = e.take & ~rst;
    return e;
endfunction

`endif

//--- dv/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage;
    import mips_isa_pkg::*;
    import id_pkg::*;

    // 2 reset, 20 directed and 400 random cycles, with generous margin
    localparam int RUN_CYCLES = 2 + 20 + 400;
    localparam int MAX_CYCLES = 1000;
    // wide enough for a whole slot_out_t
    localparam int CHK_W = $bits(slot_out_t);

    logic        clk;
    logic        reset_i;
    word_t       pc;
    inst_word_u  inst1;
    inst_word_u  inst2;
    reg_write_t  wb [2];
    reg_write_t  exe_fwd [2];
    reg_write_t  mem_fwd [2];
    slot_out_t   slot1;
    slot_out_t   slot2;
    issue_mode_t issue_mode;
    logic        jmp_take;
    word_t       jmp_target;
    word_t       link_addr;

    logic [31:0] seed = 32'hf653d3e0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    `include "id_ref_model.svh"

    id_stage i_dut (
        .clk(clk), .reset_i(reset_i), .pc_i(pc), .inst1_i(inst1), .inst2_i(inst2),
        .wb_i(wb), .exe_fwd_i(exe_fwd), .mem_fwd_i(mem_fwd),
        .slot1_o(slot1), .slot2_o(slot2), .issue_mode_o(issue_mode),
        .jmp_take_o(jmp_take), .jmp_target_o(jmp_target), .link_addr_o(link_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic inst_word_u r_inst(input funct_t f, input reg_addr_t rs,
                                          input reg_addr_t rt, input reg_addr_t rd,
                                          input logic [4:0] sa);
        inst_word_u w;
        w.r = '{OPC_SPECIAL, rs, rt, rd, sa, f};
        return w;
    endfunction

    function automatic inst_word_u i_inst(input opcode_t op, input reg_addr_t rs,
                                          input reg_addr_t rt, input logic [15:0] imm);
        inst_word_u w;
        w.i = '{op, rs, rt, imm};
        return w;
    endfunction

    function automatic reg_addr_t rand_reg();
        logic [31:0] r;
        r = next_rand();
        return {2'b00, r[20:18]};
    endfunction

    function automatic inst_word_u rand_inst();
        logic [31:0] r;
        r = next_rand();
        case (r[27:24])
            4'd0:  return r_inst(FN_ADDU, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            4'd1:  return r_inst(FN_SUBU, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            4'd2:  return r_inst(FN_AND, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            4'd3:  return r_inst(FN_OR, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            4'd4:  return r_inst(FN_XOR, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            4'd5:  return r_inst(FN_SLT, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            4'd6:  return r_inst(FN_SLL, 5'd0, rand_reg(), rand_reg(), r[4:0]);
            4'd7:  return r_inst(FN_SRL, 5'd0, rand_reg(), rand_reg(), r[4:0]);
            4'd8:  return r_inst(FN_JR, rand_reg(), 5'd0, 5'd0, 5'd0);
            4'd9:  return i_inst(OPC_ADDIU, rand_reg(), rand_reg(), r[15:0]);
            4'd10: return i_inst(OPC_ANDI, rand_reg(), rand_reg(), r[15:0]);
            4'd11: return i_inst(OPC_ORI, rand_reg(), rand_reg(), r[15:0]);
            4'd12: return i_inst(OPC_LUI, 5'd0, rand_reg(), r[15:0]);
            4'd13: return i_inst(OPC_SLTI, rand_reg(), rand_reg(), r[15:0]);
            4'd14: return i_inst(r[31] ? OPC_BEQ : OPC_BNE, rand_reg(), rand_reg(), r[15:0]);
            default: return i_inst(r[31] ? OPC_J : OPC_JAL, r[20:16], r[12:8], r[15:0]);
        endcase
    endfunction

    function automatic reg_write_t rand_write();
        logic [31:0] r;
        r = next_rand();
        return '{r[31] & r[30], rand_reg(), next_rand()};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_sources();
        wb[0] = '0;
        wb[1] = '0;
        exe_fwd[0] = '0;
        exe_fwd[1] = '0;
        mem_fwd[0] = '0;
        mem_fwd[1] = '0;
    endtask

    task automatic check_val(input string name, input logic [CHK_W-1:0] exp,
                             input logic [CHK_W-1:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Error: %0t ns %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    always @(posedge clk) begin
        update_model(reset_i, wb);
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the stimulus never finished", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // compares near the end of each cycle, after all inputs settled
    initial begin
        expect_t e;
        forever begin
            @(posedge clk);
            #19;
            e = expect_ref(inst1, inst2, pc, reset_i, wb, exe_fwd, mem_fwd);
            check_val("slot1_o", CHK_W'(e.s1), CHK_W'(slot1));
            check_val("slot2_o", CHK_W'(e.s2), CHK_W'(slot2));
            check_val("issue_mode_o", CHK_W'(e.im), CHK_W'(issue_mode));
            check_val("jmp_take_o", CHK_W'(e.take), CHK_W'(jmp_take));
            check_val("link_addr_o", CHK_W'(e.link), CHK_W'(link_addr));
            if (e.jk1 != JMP_NONE) begin
                check_val("jmp_target_o", CHK_W'(e.target), CHK_W'(jmp_target));
            end
        end
    end

    initial begin
        reset_i = 1'b1;
        pc = 32'h0040_0000;
        inst1 = r_inst(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0);
        inst2 = i_inst(OPC_BEQ, 5'd1, 5'd2, 16'h0004);
        clear_sources();
        repeat (2) @(posedge clk);
        #2;
        reset_i = 1'b0;
        // register file: bypass, port 2 priority, register 0
        inst1 = r_inst(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0);
        inst2 = r_inst(FN_OR, 5'd4, 5'd5, 5'd6, 5'd0);
        next_cycle();
        wb[0] = '{1'b1, 5'd5, 32'haaaa_0005};
        wb[1] = '{1'b1, 5'd6, 32'hbbbb_0006};
        inst1 = r_inst(FN_ADDU, 5'd5, 5'd6, 5'd7, 5'd0);
        next_cycle();
        wb[0] = '{1'b1, 5'd6, 32'h1111_1111};
        wb[1] = '{1'b1, 5'd6, 32'h2222_2222};
        inst1 = r_inst(FN_ADDU, 5'd5, 5'd6, 5'd8, 5'd0);
        next_cycle();
        wb[0] = '{1'b1, 5'd0, 32'hdead_beef};
        wb[1] = '0;
        inst1 = r_inst(FN_ADDU, 5'd6, 5'd0, 5'd9, 5'd0);
        inst2 = r_inst(FN_XOR, 5'd0, 5'd5, 5'd10, 5'd0);
        // forwarding priority, dropping the newest source each cycle
        for (int k = 0; k < 5; k++) begin
            next_cycle();
            clear_sources();
            exe_fwd[1] = '{k < 1, 5'd5, 32'h0000_e002};
            exe_fwd[0] = '{k < 2, 5'd5, 32'h0000_e001};
            mem_fwd[1] = '{k < 3, 5'd5, 32'h0000_a002};
            mem_fwd[0] = '{k < 4, 5'd5, 32'h0000_a001};
            inst1 = r_inst(FN_SUBU, 5'd5, 5'd5, 5'd11, 5'd0);
            inst2 = r_inst(FN_SLT, 5'd6, 5'd5, 5'd12, 5'd0);
        end
        next_cycle();
        exe_fwd[1] = '{1'b1, 5'd0, 32'h1234_5678};
        mem_fwd[0] = '{1'b1, 5'd0, 32'h8765_4321};
        inst1 = r_inst(FN_ADDU, 5'd0, 5'd0, 5'd1, 5'd0);
        // immediates and shifts
        next_cycle();
        clear_sources();
        inst1 = i_inst(OPC_ADDIU, 5'd5, 5'd13, 16'h8001);
        inst2 = i_inst(OPC_ANDI, 5'd6, 5'd14, 16'h8001);
        next_cycle();
        inst1 = i_inst(OPC_LUI, 5'd0, 5'd15, 16'hbeef);
        inst2 = i_inst(OPC_SLTI, 5'd5, 5'd16, 16'hfff0);
        next_cycle();
        inst1 = r_inst(FN_SLL, 5'd0, 5'd5, 5'd17, 5'd7);
        inst2 = i_inst(OPC_ORI, 5'd6, 5'd18, 16'h00ff);
        // RAW, WAW and a register 0 dependency
        next_cycle();
        inst1 = r_inst(FN_ADDU, 5'd5, 5'd6, 5'd19, 5'd0);
        inst2 = r_inst(FN_SRL, 5'd0, 5'd19, 5'd20, 5'd3);
        next_cycle();
        inst2 = r_inst(FN_AND, 5'd5, 5'd6, 5'd19, 5'd0);
        next_cycle();
        inst1 = r_inst(FN_ADDU, 5'd5, 5'd6, 5'd0, 5'd0);
        inst2 = r_inst(FN_OR, 5'd0, 5'd0, 5'd21, 5'd0);
        // control transfer in slot 1
        next_cycle();
        pc = 32'h8000_1000;
        inst1 = i_inst(OPC_JAL, 5'd3, 5'd4, 16'h0123);
        next_cycle();
        inst1 = r_inst(FN_JR, 5'd6, 5'd0, 5'd0, 5'd0);
        next_cycle();
        inst1 = i_inst(OPC_BEQ, 5'd6, 5'd6, 16'hfffc);
        next_cycle();
        inst1 = i_inst(OPC_BNE, 5'd5, 5'd6, 16'h0010);
        inst2 = i_inst(OPC_J, 5'd1, 5'd1, 16'h0001);
        for (int c = 0; c < 400; c++) begin
            next_cycle();
            reset_i = (c >= 200 && c < 202);
            pc = {next_rand()} & 32'hffff_fffc;
            inst1 = rand_inst();
            inst2 = rand_inst();
            wb[0] = reset_i ? '0 : rand_write();
            wb[1] = reset_i ? '0 : rand_write();
            exe_fwd[0] = rand_write();
            exe_fwd[1] = rand_write();
            mem_fwd[0] = rand_write();
            mem_fwd[1] = rand_write();
        end
        @(posedge clk);
        #1;
        $display("errors: %0d of %0d checks over %0d cycles (planned %0d)",
                 errors, checks, cycles, RUN_CYCLES);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+dv
rtl/mips_isa_pkg.sv
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/operand_select.sv
rtl/regfile.sv
rtl/issue_ctrl.sv
rtl/branch_unit.sv
rtl/id_stage.sv
dv/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing -f sim.f --top-module tb_id_stage -o sim_id_stage
./obj_dir/sim_id_stage > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation completed successfully" sim.log; then
    echo "run passed"
else
    echo "run failed"
    exit 1
fi
